// File: run.sh
#!/usr/bin/env bash
# Build and run the lane testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wall -Wno-fatal \
	-f tb.f --top-module laneTb -o laneSim

status=0
output=$(./obj_dir/laneSim 2>&1) || status=$?
echo "$output"

if [ "$status" -eq 0 ] && echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
else
	exit 1
fi

// File: source/execUnit.sv
// Lane execution unit
// Two-stage integer pipeline for add, sub, mul and multiply-accumulate
// Stage 1 holds the finished result, stage 2 is the commit register

`default_nettype none

module execUnit (
	input  wire logic             clock,
	input  wire logic             rstN,
	input  wire logic             opValid,
	input  wire lanePkg::opCode_t opCode,
	input  wire lanePkg::index_t  opDst,
	input  wire lanePkg::data_t   operand1,
	input  wire lanePkg::data_t   operand2,
	input  wire lanePkg::data_t   operand3,
	output logic                  wbValid1,
	output logic                  wbValid2,
	output lanePkg::index_t       wbIdx1,
	output lanePkg::index_t       wbIdx2,
	output lanePkg::data_t        wbData1,
	output lanePkg::data_t        wbData2
);

	lanePkg::data_t product;	// Low half of src1 * src2
	lanePkg::data_t aluResult;

	assign product = operand1 * operand2;

	always_comb begin
		case (opCode)
			lanePkg::opAdd: aluResult = operand1 + operand2;
			lanePkg::opSub: aluResult = operand1 - operand2;
			lanePkg::opMul: aluResult = product;
			lanePkg::opMac: aluResult = product + operand3;
			default:        aluResult = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Pipeline valids

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			wbValid1 <= 1'b0;
			wbValid2 <= 1'b0;
		end else begin
			wbValid1 <= opValid;
			wbValid2 <= wbValid1;
		end
	end

	//////////////////////////////////////////////////
	// Result and destination

	always_ff @(posedge clock) begin
		if (opValid) begin
			wbIdx1  <= opDst;
			wbData1 <= aluResult;
		end
		if (wbValid1) begin
			wbIdx2  <= wbIdx1;	// Commit stage
			wbData2 <= wbData1;
		end
	end

endmodule

`default_nettype wire

// File: source/lanePkg.sv
// Lane package
// Width types, operand selectors and state encodings used across the lane

`default_nettype none

`include "lane_settings.svh"

package lanePkg;

	typedef logic [`DATA_WIDTH-1:0] data_t;	// One operand or result
	typedef logic [`INDEX_WIDTH-1:0] index_t;	// Register number
	typedef logic [31:0] address_t;	// Byte address, stride or beat count

	typedef logic [2:0] srcSel_t;	// Bit 2 enable, bits 1:0 read port
	typedef logic [1:0] pathSel_t;	// Load/store port rotation

	typedef enum logic [1:0] {
		opAdd,	// src1 + src2
		opSub,	// src1 - src2
		opMul,	// src1 * src2, low half
		opMac	// src1 * src2 + src3
	} opCode_t;

	typedef enum logic {
		genIdle,
		genRun
	} genState_t;

endpackage

`default_nettype wire

// File: source/laneTop.sv
// Vector BLAS lane
// Register file, operand network, execution pipeline and load/store
// address generator with a one-cycle issue register ahead of the network

`default_nettype none

module laneTop (
	input  wire logic               clock,
	input  wire logic               rstN,
	input  wire logic               issueValid,
	input  wire lanePkg::opCode_t   opCode,
	input  wire lanePkg::index_t    dstIdx,
	input  wire lanePkg::index_t    rdIdx1,
	input  wire lanePkg::index_t    rdIdx2,
	input  wire lanePkg::index_t    rdIdx3,
	input  wire lanePkg::index_t    rdIdx4,
	input  wire lanePkg::srcSel_t   selSrc1,
	input  wire lanePkg::srcSel_t   selSrc2,
	input  wire lanePkg::srcSel_t   selSrc3,
	input  wire lanePkg::pathSel_t  selPath,
	input  wire logic               hostWrEn,
	input  wire lanePkg::index_t    hostWrIdx,
	input  wire lanePkg::data_t     hostWrData,
	input  wire logic               memReady,
	output logic                    memValid,
	output lanePkg::address_t       memAddr,
	output logic                    ldStBusy,
	output logic                    resultValid,
	output lanePkg::index_t         resultIdx,
	output lanePkg::data_t          resultData
);

	lanePkg::data_t    srcData1, srcData2, srcData3, srcData4;
	lanePkg::index_t   srcIdx1, srcIdx2, srcIdx3, srcIdx4;
	logic              reqValid;
	lanePkg::opCode_t  reqOp;
	lanePkg::index_t   reqDst;
	lanePkg::srcSel_t  reqSel1, reqSel2, reqSel3;
	lanePkg::pathSel_t reqPath;
	logic              opValid;
	lanePkg::opCode_t  exOp;
	lanePkg::index_t   exDst;
	lanePkg::data_t    operand1, operand2, operand3;
	logic              wbValid1, wbValid2;
	lanePkg::index_t   wbIdx1, wbIdx2;
	lanePkg::data_t    wbData1, wbData2;
	logic              descValid;
	lanePkg::address_t descAddr, descStride, descLength;
	logic              wrEn;
	lanePkg::index_t   wrIdx;
	lanePkg::data_t    wrData;

	//////////////////////////////////////////////////
	// Issue register, aligned with the read latency

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			reqValid <= 1'b0;
		end else begin
			reqValid <= issueValid;
		end
	end

	always_ff @(posedge clock) begin
		reqOp   <= opCode;
		reqDst  <= dstIdx;
		reqSel1 <= selSrc1;
		reqSel2 <= selSrc2;
		reqSel3 <= selSrc3;
		reqPath <= selPath;
	end

	// Commit wins the write port over the host
	assign wrEn   = wbValid2 || hostWrEn;
	assign wrIdx  = wbValid2 ? wbIdx2 : hostWrIdx;
	assign wrData = wbValid2 ? wbData2 : hostWrData;

	assign resultValid = wbValid2;
	assign resultIdx   = wbIdx2;
	assign resultData  = wbData2;

	//////////////////////////////////////////////////
	// Blocks

	regFile regFile_i (
		.clock, .rstN, .rdIdx1, .rdIdx2, .rdIdx3, .rdIdx4, .wrEn, .wrIdx, .wrData,
		.srcData1, .srcData2, .srcData3, .srcData4, .srcIdx1, .srcIdx2, .srcIdx3, .srcIdx4
	);

	operandNetwork operandNetwork_i (
		.reqValid, .reqOp, .reqDst,
		.selSrc1(reqSel1), .selSrc2(reqSel2), .selSrc3(reqSel3), .selPath(reqPath),
		.srcData1, .srcData2, .srcData3, .srcData4, .srcIdx1, .srcIdx2, .srcIdx3, .srcIdx4,
		.wbValid1, .wbValid2, .wbIdx1, .wbIdx2, .wbData1, .wbData2,
		.opValid, .opCode(exOp), .opDst(exDst), .operand1, .operand2, .operand3,
		.descValid, .descAddr, .descStride, .descLength
	);

	execUnit execUnit_i (
		.clock, .rstN, .opValid, .opCode(exOp), .opDst(exDst),
		.operand1, .operand2, .operand3,
		.wbValid1, .wbValid2, .wbIdx1, .wbIdx2, .wbData1, .wbData2
	);

	memRequestGen memRequestGen_i (
		.clock, .rstN, .descValid, .descAddr, .descStride, .descLength,
		.memReady, .memValid, .memAddr, .busy(ldStBusy)
	);

endmodule

`default_nettype wire

// File: source/lane_settings.svh
// Lane build settings
// Data path width and register file geometry shared by all lane blocks

`ifndef LANE_SETTINGS_SVH
`define LANE_SETTINGS_SVH

//////////////////////////////////////////////////
// Data path

// Operand and result width in bits
`define DATA_WIDTH 32

//////////////////////////////////////////////////
// Register file

// Number of architectural registers
`define NUM_REGS 32

// Bits needed to name one register
`define INDEX_WIDTH 5

`endif

// File: source/memRequestGen.sv
// Lane memory request generator
// Emits one strided address per accepted valid/ready beat for a descriptor

`default_nettype none

module memRequestGen (
	input  wire logic               clock,
	input  wire logic               rstN,
	input  wire logic               descValid,
	input  wire lanePkg::address_t  descAddr,
	input  wire lanePkg::address_t  descStride,
	input  wire lanePkg::address_t  descLength,
	input  wire logic               memReady,
	output logic                    memValid,
	output lanePkg::address_t       memAddr,
	output logic                    busy
);

	lanePkg::genState_t state;
	lanePkg::address_t  curAddr;
	lanePkg::address_t  curStride;
	lanePkg::address_t  beatsLeft;	// Beats still to transfer
	logic               beatDone;

	assign memValid = (state == lanePkg::genRun);
	assign memAddr  = curAddr;	// Held until the beat transfers
	assign beatDone = memValid && memReady;
	assign busy     = descValid || (state == lanePkg::genRun);

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= lanePkg::genIdle;
		end else begin
			case (state)
				lanePkg::genIdle: begin
					if (descValid && (descLength != '0)) begin
						state <= lanePkg::genRun;	// Zero length emits nothing
					end
				end
				lanePkg::genRun: begin
					if (beatDone && (beatsLeft == 32'd1)) begin
						state <= lanePkg::genIdle;
					end
				end
				default: state <= lanePkg::genIdle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ((state == lanePkg::genIdle) && descValid) begin
			curAddr   <= descAddr;
			curStride <= descStride;
			beatsLeft <= descLength;
		end else if (beatDone) begin
			curAddr   <= curAddr + curStride;
			beatsLeft <= beatsLeft - 32'd1;
		end
	end

endmodule

`default_nettype wire

// File: source/operandNetwork.sv
// Lane operand network
// Routes up to three operands from the read ports with writeback bypass,
// or rotates the four read values into a load/store descriptor

`default_nettype none

module operandNetwork (
	input  wire logic              reqValid,
	input  wire lanePkg::opCode_t  reqOp,
	input  wire lanePkg::index_t   reqDst,
	input  wire lanePkg::srcSel_t  selSrc1,
	input  wire lanePkg::srcSel_t  selSrc2,
	input  wire lanePkg::srcSel_t  selSrc3,
	input  wire lanePkg::pathSel_t selPath,
	input  wire lanePkg::data_t    srcData1,
	input  wire lanePkg::data_t    srcData2,
	input  wire lanePkg::data_t    srcData3,
	input  wire lanePkg::data_t    srcData4,
	input  wire lanePkg::index_t   srcIdx1,
	input  wire lanePkg::index_t   srcIdx2,
	input  wire lanePkg::index_t   srcIdx3,
	input  wire lanePkg::index_t   srcIdx4,
	input  wire logic              wbValid1,
	input  wire logic              wbValid2,
	input  wire lanePkg::index_t   wbIdx1,
	input  wire lanePkg::index_t   wbIdx2,
	input  wire lanePkg::data_t    wbData1,
	input  wire lanePkg::data_t    wbData2,
	output logic                   opValid,
	output lanePkg::opCode_t       opCode,
	output lanePkg::index_t        opDst,
	output lanePkg::data_t         operand1,
	output lanePkg::data_t         operand2,
	output lanePkg::data_t         operand3,
	output logic                   descValid,
	output lanePkg::address_t      descAddr,
	output lanePkg::address_t      descStride,
	output lanePkg::address_t      descLength
);

	lanePkg::data_t   portData [4];
	lanePkg::index_t  portIdx [4];
	lanePkg::srcSel_t opSel [3];
	lanePkg::data_t   routed [3];
	logic [2:0]       srcEn;	// Per-operand enable bits
	logic             isLdSt;
	logic [1:0]       strideSel;
	logic [1:0]       lengthSel;

	assign portData[0] = srcData1;
	assign portData[1] = srcData2;
	assign portData[2] = srcData3;
	assign portData[3] = srcData4;
	assign portIdx[0]  = srcIdx1;
	assign portIdx[1]  = srcIdx2;
	assign portIdx[2]  = srcIdx3;
	assign portIdx[3]  = srcIdx4;
	assign opSel[0]    = selSrc1;
	assign opSel[1]    = selSrc2;
	assign opSel[2]    = selSrc3;

	//////////////////////////////////////////////////
	// ALU operand routing

	for (genvar k = 0; k < 3; k++) begin : genOperand
		lanePkg::index_t idx;
		lanePkg::data_t  regData;
		logic            hitWb1;
		logic            hitWb2;

		assign srcEn[k] = opSel[k][2];
		assign idx      = portIdx[opSel[k][1:0]];
		assign regData  = portData[opSel[k][1:0]];
		assign hitWb1   = wbValid1 && (wbIdx1 == idx);	// Newest in-flight value
		assign hitWb2   = wbValid2 && (wbIdx2 == idx);

		assign routed[k] = (!reqValid || !srcEn[k]) ? '0 :
			hitWb1 ? wbData1 :
			hitWb2 ? wbData2 :
			regData;
	end

	assign opValid  = reqValid && (|srcEn);
	assign opCode   = reqOp;
	assign opDst    = reqDst;
	assign operand1 = routed[0];
	assign operand2 = routed[1];
	assign operand3 = routed[2];

	//////////////////////////////////////////////////
	// Load/store descriptor

	// No operand enabled means the read ports carry a descriptor
	assign isLdSt    = reqValid && !(|srcEn);
	assign strideSel = selPath + 2'd1;	// Wraps modulo 4
	assign lengthSel = selPath + 2'd2;

	assign descValid  = isLdSt;
	assign descAddr   = isLdSt ? lanePkg::address_t'(portData[selPath]) : '0;
	assign descStride = isLdSt ? lanePkg::address_t'(portData[strideSel]) : '0;
	assign descLength = isLdSt ? lanePkg::address_t'(portData[lengthSel]) : '0;

endmodule

`default_nettype wire

// File: source/regFile.sv
// Lane register file
// Four registered read ports and one write port
// A read of the register written on the same edge returns the new word

`default_nettype none

`include "lane_settings.svh"

module regFile (
	input  wire logic             clock,
	input  wire logic             rstN,
	input  wire lanePkg::index_t  rdIdx1,
	input  wire lanePkg::index_t  rdIdx2,
	input  wire lanePkg::index_t  rdIdx3,
	input  wire lanePkg::index_t  rdIdx4,
	input  wire logic             wrEn,
	input  wire lanePkg::index_t  wrIdx,
	input  wire lanePkg::data_t   wrData,
	output lanePkg::data_t        srcData1,
	output lanePkg::data_t        srcData2,
	output lanePkg::data_t        srcData3,
	output lanePkg::data_t        srcData4,
	output lanePkg::index_t       srcIdx1,
	output lanePkg::index_t       srcIdx2,
	output lanePkg::index_t       srcIdx3,
	output lanePkg::index_t       srcIdx4
);

	lanePkg::data_t regs [`NUM_REGS];	// Architectural state

	// Read with write-through from the port written this cycle
	function automatic lanePkg::data_t readPort(input lanePkg::index_t idx);
		if (wrEn && (wrIdx == idx)) begin
			return wrData;
		end
		return regs[idx];
	endfunction

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			srcData1 <= '0;
			srcData2 <= '0;
			srcData3 <= '0;
			srcData4 <= '0;
			srcIdx1  <= '0;
			srcIdx2  <= '0;
			srcIdx3  <= '0;
			srcIdx4  <= '0;
		end else begin
			if (wrEn) begin
				regs[wrIdx] <= wrData;	// Commit or host write
			end
			srcData1 <= readPort(rdIdx1);
			srcData2 <= readPort(rdIdx2);
			srcData3 <= readPort(rdIdx3);
			srcData4 <= readPort(rdIdx4);
			srcIdx1  <= rdIdx1;	// Index follows data for bypass compare
			srcIdx2  <= rdIdx2;
			srcIdx3  <= rdIdx3;
			srcIdx4  <= rdIdx4;
		end
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/lanePkg.sv
source/regFile.sv
source/operandNetwork.sv
source/execUnit.sv
source/memRequestGen.sv
source/laneTop.sv
test/lane_asserts.sv
test/laneTb.sv

// File: test/laneTb.sv
// Lane testbench
// Table-driven ALU and load/store stimulus checked against a register model

`default_nettype none

module laneTb;

	typedef struct {
		lanePkg::opCode_t op;
		int               dst;
		int               rd [4];
		lanePkg::srcSel_t sel [3];
		int               gap;	// Cycles until the next issue
	} instr_t;

	logic clock, rstN, issueValid, hostWrEn, memReady, memValid, ldStBusy, resultValid;
	lanePkg::opCode_t  opCode;
	lanePkg::index_t   dstIdx, rdIdx1, rdIdx2, rdIdx3, rdIdx4, hostWrIdx, resultIdx;
	lanePkg::srcSel_t  selSrc1, selSrc2, selSrc3;
	lanePkg::pathSel_t selPath;
	lanePkg::data_t    hostWrData, resultData;
	lanePkg::address_t memAddr;

	logic [31:0] lfsrState = 32'd95202;
	logic [31:0] refRegs [32];
	logic [31:0] expData [$];
	int          expIdx [$];
	int          expCycle [$];
	logic [31:0] expAddr [$];
	instr_t      prog [$];
	int          cycle = 0;
	logic        readyRandom = 1'b0;

	laneTop dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) cycle <= cycle + 1;

	// Galois LFSR, one step per bit
	function automatic logic nextBit();
		logic b;
		b = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (b) lfsrState = lfsrState ^ 32'hA300_0000;
		return b;
	endfunction

	function automatic logic [31:0] nextWord();
		logic [31:0] w;
		for (int i = 0; i < 32; i++) w = {w[30:0], nextBit()};
		return w;
	endfunction

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		stopRun($sformatf("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	// One cycle, then memory back-pressure for the new cycle
	task automatic step();
		@(posedge clock);
		#1;
		memReady = readyRandom ? nextBit() : 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Monitors, sampled mid-cycle

	always @(negedge clock) begin
		if (rstN && resultValid) begin
			assert (expData.size() > 0) else stopRun("result appeared with none outstanding");
			assert (resultIdx == expIdx[0]) else reportMismatch("resultIdx", expIdx[0], resultIdx);
			assert (resultData == expData[0]) else reportMismatch("resultData", expData[0], resultData);
			assert (cycle == expCycle[0]) else reportMismatch("result cycle", expCycle[0], cycle);
			void'(expIdx.pop_front());
			void'(expData.pop_front());
			void'(expCycle.pop_front());
		end
		if (rstN && memValid && memReady) begin
			assert (expAddr.size() > 0) else stopRun("memory beat beyond the descriptor length");
			assert (memAddr == expAddr[0]) else reportMismatch("memAddr", expAddr[0], memAddr);
			void'(expAddr.pop_front());
		end
	end

	//////////////////////////////////////////////////
	// Stimulus helpers

	task automatic applyReset();
		rstN = 1'b0;
		repeat (8) step();
		rstN = 1'b1;
		for (int i = 0; i < 32; i++) refRegs[i] = '0;
		assert (!resultValid && !memValid && !ldStBusy) else stopRun("outputs active after reset");
	endtask

	task automatic hostWrite(input int idx, input logic [31:0] data);
		hostWrEn = 1'b1;
		hostWrIdx = lanePkg::index_t'(idx);
		hostWrData = data;
		refRegs[idx] = data;
		step();
		hostWrEn = 1'b0;
	endtask

	task automatic addInstr(input lanePkg::opCode_t op, input int dst, input int r1, input int r2,
			input int r3, input int r4, input logic [2:0] s1, input logic [2:0] s2,
			input logic [2:0] s3, input int gap);
		instr_t ins;
		ins.op = op;
		ins.dst = dst;
		ins.rd = '{r1, r2, r3, r4};
		ins.sel = '{s1, s2, s3};
		ins.gap = gap;
		prog.push_back(ins);
	endtask

	// Reference result from sequential register semantics
	task automatic issueAlu(input instr_t ins);
		logic [31:0] opnd [3];
		logic [31:0] res;
		for (int k = 0; k < 3; k++) begin
			opnd[k] = ins.sel[k][2] ? refRegs[ins.rd[ins.sel[k][1:0]]] : 32'd0;
		end
		case (ins.op)
			lanePkg::opAdd: res = opnd[0] + opnd[1];
			lanePkg::opSub: res = opnd[0] - opnd[1];
			lanePkg::opMul: res = opnd[0] * opnd[1];
			default:        res = opnd[0] * opnd[1] + opnd[2];
		endcase
		refRegs[ins.dst] = res;
		expIdx.push_back(ins.dst);
		expData.push_back(res);
		expCycle.push_back(cycle + 3);
		{issueValid, opCode, dstIdx} = {1'b1, ins.op, lanePkg::index_t'(ins.dst)};
		{rdIdx1, rdIdx2, rdIdx3, rdIdx4} = {5'(ins.rd[0]), 5'(ins.rd[1]), 5'(ins.rd[2]),
			5'(ins.rd[3])};
		{selSrc1, selSrc2, selSrc3} = {ins.sel[0], ins.sel[1], ins.sel[2]};
		step();
		issueValid = 1'b0;
		repeat (ins.gap - 1) step();
	endtask

	task automatic waitDrain();
		int n;
		n = 0;
		while (expData.size() > 0 || expAddr.size() > 0 || ldStBusy) begin
			if (n == 200) stopRun("timeout waiting for the lane to drain");
			step();
			n++;
		end
	endtask

	// Load/store through ports rotated by path, descriptor in r28..r30
	task automatic runLdSt(input int path, input logic [31:0] addr, input logic [31:0] stride,
			input logic [31:0] len);
		int n;
		hostWrite(28, addr);
		hostWrite(29, stride);
		hostWrite(30, len);
		hostWrite(31, nextWord());
		for (int k = 0; k < len; k++) expAddr.push_back(addr + k * stride);
		issueValid = 1'b1;
		selPath = lanePkg::pathSel_t'(path);
		{selSrc1, selSrc2, selSrc3} = '0;
		rdIdx1 = 5'(28 + ((4 - path) % 4));
		rdIdx2 = 5'(28 + ((5 - path) % 4));
		rdIdx3 = 5'(28 + ((6 - path) % 4));
		rdIdx4 = 5'(28 + ((7 - path) % 4));
		step();
		issueValid = 1'b0;
		assert (ldStBusy) else reportMismatch("ldStBusy", 1, ldStBusy);
		n = 0;
		while (ldStBusy) begin
			if (n == 200) stopRun("timeout waiting for ldStBusy to fall");
			step();
			n++;
		end
		assert (expAddr.size() == 0) else reportMismatch("beats missing", 0, expAddr.size());
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		{issueValid, hostWrEn, memReady, rstN} = '0;
		{opCode, dstIdx, rdIdx1, rdIdx2, rdIdx3, rdIdx4} = '0;
		{selSrc1, selSrc2, selSrc3, selPath, hostWrIdx, hostWrData} = '0;
		#1;
		applyReset();
		for (int i = 0; i < 28; i++) hostWrite(i, nextWord());

		addInstr(lanePkg::opAdd, 1, 2, 3, 0, 0, 3'b100, 3'b101, 3'b000, 4);
		addInstr(lanePkg::opSub, 4, 5, 6, 0, 0, 3'b100, 3'b101, 3'b000, 4);
		addInstr(lanePkg::opMul, 7, 8, 9, 0, 0, 3'b100, 3'b101, 3'b000, 4);
		addInstr(lanePkg::opMac, 10, 11, 12, 13, 0, 3'b100, 3'b101, 3'b110, 4);
		addInstr(lanePkg::opAdd, 14, 1, 2, 0, 0, 3'b100, 3'b101, 3'b000, 1);
		addInstr(lanePkg::opMul, 15, 14, 3, 0, 0, 3'b100, 3'b101, 3'b000, 2);
		addInstr(lanePkg::opSub, 16, 15, 14, 0, 0, 3'b100, 3'b101, 3'b000, 3);
		addInstr(lanePkg::opAdd, 17, 0, 0, 0, 16, 3'b111, 3'b000, 3'b000, 4);
		addInstr(lanePkg::opMac, 18, 10, 7, 4, 0, 3'b110, 3'b101, 3'b100, 1);
		addInstr(lanePkg::opMac, 18, 18, 0, 0, 0, 3'b100, 3'b100, 3'b100, 1);
		addInstr(lanePkg::opSub, 19, 0, 0, 0, 18, 3'b111, 3'b000, 3'b000, 1);
		addInstr(lanePkg::opAdd, 20, 0, 0, 19, 0, 3'b000, 3'b110, 3'b000, 4);
		foreach (prog[i]) issueAlu(prog[i]);
		waitDrain();

		readyRandom = 1'b1;	// Back-pressure on the memory side
		runLdSt(0, 32'h0000_1000, 32'd4, 32'd5);
		runLdSt(1, 32'h2000_0000, 32'h10, 32'd3);
		runLdSt(2, 32'hFFFF_FFF0, 32'd8, 32'd4);
		runLdSt(3, 32'h0000_0040, 32'hFFFF_FFFC, 32'd6);
		runLdSt(0, 32'h0000_0500, 32'd4, 32'd0);
		readyRandom = 1'b0;
		waitDrain();

		// Read every register back as r + 0 after a fresh reset
		applyReset();
		prog.delete();
		for (int i = 0; i < 32; i++) begin
			addInstr(lanePkg::opAdd, i, i, 0, 0, 0, 3'b100, 3'b000, 3'b000, 1);
		end
		foreach (prog[i]) issueAlu(prog[i]);
		waitDrain();

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/lane_asserts.sv
// Lane protocol checks
// Bound to the lane top, covering reset state, the memory handshake,
// write port sharing and load/store issue rules

`default_nettype none

module laneAsserts (
	input wire logic              clock,
	input wire logic              rstN,
	input wire logic              issueValid,
	input wire lanePkg::srcSel_t  selSrc1,
	input wire lanePkg::srcSel_t  selSrc2,
	input wire lanePkg::srcSel_t  selSrc3,
	input wire logic              hostWrEn,
	input wire logic              memReady,
	input wire logic              memValid,
	input wire lanePkg::address_t memAddr,
	input wire logic              ldStBusy,
	input wire logic              resultValid
);

	logic ldStIssue;	// Issue with no operand enabled

	assign ldStIssue = issueValid && !(selSrc1[2] || selSrc2[2] || selSrc3[2]);

	resetQuiet: assert property (@(posedge clock) !rstN |-> !resultValid && !memValid && !ldStBusy)
		else $error("lane outputs active during reset");

	memHold: assert property (@(posedge clock) disable iff (!rstN)
		memValid && !memReady |=> memValid && $stable(memAddr))
		else $error("memory request changed before it was accepted");

	wrCollide: assert property (@(posedge clock) disable iff (!rstN) !(hostWrEn && resultValid))
		else $error("host write collides with a commit");

	ldStWhileBusy: assert property (@(posedge clock) disable iff (!rstN) !(ldStIssue && ldStBusy))
		else $error("load/store issued while the request generator is busy");

endmodule

bind laneTop laneAsserts laneAsserts_i (.*);

`default_nettype wire
